// ==== st_settings.svh ====
`ifndef ST_SETTINGS_SVH
`define ST_SETTINGS_SVH

// clock rates in Hz
`define ST_SYSTEM_CLOCK 32'd32_084_988 // clk_32 as it really runs
`define ST_MFP_CLOCK    32'd2_457_600  // mfp timer reference
`define ST_MFP_ACC_W    32             // fractional accumulator width

// power-on reset sequencer
`define ST_RESET_CNT    7'd127 // reload value of the down-counter
`define ST_MCU_RST_ON   7'd10  // mcu reset goes low after this count
`define ST_MCU_RST_OFF  7'd8   // and comes back once below this one

// 32 MHz / 16 gives the psg clock
`define ST_DIV2M_W      4

// gemdos counts years from 1980
`define ST_RTC_YEAR_OFS 4'd2

// host register map, byte addresses
`define ST_REG_TIME_LO  8'h40 // time bits 31..0
`define ST_REG_TIME_HI  8'h44 // time bits 51..32
`define ST_AXI_AW       8

`endif

// ==== st_pkg.sv ====
package st_pkg;

	// audio samples
	typedef logic [9:0] ym_sample_t;           // psg mix, offset binary
	typedef logic [7:0] dma_sample_t;          // ste dma sound, offset binary
	typedef logic signed [14:0] mix_sample_t;  // goes to the sigma-delta dac

	// rp5c15 register file
	typedef logic [3:0] rtc_nib_t;
	typedef logic [3:0] rtc_addr_t;  // register index 0..15

	// bcd time from the io controller, seconds at the low end
	typedef struct packed {
		logic [3:0] dow;      // day of week
		logic [7:0] year;     // two bcd digits
		logic [7:0] month;
		logic [7:0] day;
		logic [7:0] hours;
		logic [7:0] minutes;
		logic [7:0] seconds;
	} rtc_time_t;

	// host bus
	typedef logic [31:0] axi_data_t;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10  // unmapped address
	} axi_resp_t;

endpackage

// ==== st_reset_seq.sv ====
`timescale 1ns/1ns
`include "st_settings.svh"

module st_reset_seq (
	input  logic clk_32,
	input  logic xsint,           // power-on reset, active low
	input  logic resb_i,          // reset button, active low
	output logic reset_o,         // system reset
	output logic periph_reset_o,  // peripherals, one cycle behind
	output logic mcu_reset_n_o    // memory controller, short window only
);

	logic [6:0] cnt;  // runs down to zero after every reload

	// reload on button, then count down and stop at zero
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			cnt <= `ST_RESET_CNT;
		end else if (!resb_i) begin
			cnt <= `ST_RESET_CNT;
		end else if (cnt != 7'd0) begin
			cnt <= cnt - 7'd1;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_o        <= 1'b1;
			periph_reset_o <= 1'b1;
		end else begin
			reset_o        <= (cnt != 7'd0);  // high while counting
			periph_reset_o <= reset_o;         // released one cycle later
		end
	end

	// the mcu drives the sdram clocks so it only gets a brief pulse
	// near the end of the count
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mcu_reset_n_o <= 1'b1;
		end else if (cnt == `ST_MCU_RST_ON) begin
			mcu_reset_n_o <= 1'b0;
		end else if (cnt < `ST_MCU_RST_OFF) begin
			mcu_reset_n_o <= 1'b1;  // also holds it high once idle at zero
		end
	end

endmodule

// ==== st_clk_en.sv ====
`timescale 1ns/1ns
`include "st_settings.svh"

module st_clk_en (
	input  logic clk_32,
	input  logic xsint,
	output logic clk_mfp_en_o,  // 2.4576 MHz on average
	output logic clk_2_en_o     // 2 MHz for the psg
);

	logic [`ST_MFP_ACC_W-1:0] acc;  // fractional phase in Hz units
	logic [`ST_DIV2M_W-1:0]   div;

	// add the mfp rate every cycle and wrap at the system rate
	// spacing comes out as 13 or 14 cycles
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc          <= '0;
			clk_mfp_en_o <= 1'b0;
		end else if (acc < `ST_SYSTEM_CLOCK) begin
			acc          <= acc + `ST_MFP_CLOCK;
			clk_mfp_en_o <= 1'b0;
		end else begin
			acc          <= acc - `ST_SYSTEM_CLOCK + `ST_MFP_CLOCK;  // keep the remainder
			clk_mfp_en_o <= 1'b1;
		end
	end

	// plain divide by 16
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div        <= '0;
			clk_2_en_o <= 1'b0;
		end else begin
			div        <= div + `ST_DIV2M_W'(1);
			clk_2_en_o <= (div == '1);  // one pulse per wrap
		end
	end

endmodule

// ==== st_rtc.sv ====
`timescale 1ns/1ns
`include "st_settings.svh"

module st_rtc (
	input  logic              clk_32,
	input  logic              xsint,
	input  logic              periph_reset_i,
	input  logic              we_i,         // register write strobe
	input  st_pkg::rtc_addr_t addr_i,       // shared by read and write
	input  st_pkg::rtc_nib_t  wdata_i,
	input  logic              load_lo_i,    // time bits 31..0
	input  logic              load_hi_i,    // time bits 51..32
	input  st_pkg::axi_data_t load_data_i,
	output st_pkg::rtc_nib_t  rdata_o
);

	import st_pkg::*;

	rtc_time_t tm;            // current time where zero means no rtc present
	logic      bank;          // mode register bit 0
	rtc_nib_t  bank1 [16];    // alarm and scratch nibbles

	// time value from the host
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tm <= '0;
		end else begin
			if (load_lo_i)
				tm[31:0] <= load_data_i;
			if (load_hi_i)
				tm[51:32] <= load_data_i[19:0];  // month, year and day of week
		end
	end

	// bank select lives in register 13
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			bank <= 1'b0;
		end else if (periph_reset_i) begin
			bank <= 1'b0;
		end else if (we_i && addr_i == 4'hd) begin
			bank <= wdata_i[0];
		end
	end

	// everything else lands in the bank 1 store
	always_ff @(posedge clk_32) begin
		if (we_i && addr_i != 4'hd)
			bank1[addr_i] <= wdata_i;
	end

	// rp5c15 register order
	always_comb begin
		casez ({bank, addr_i})
			5'b0_0000: rdata_o = tm.seconds[3:0];
			5'b0_0001: rdata_o = tm.seconds[7:4];
			5'b0_0010: rdata_o = tm.minutes[3:0];
			5'b0_0011: rdata_o = tm.minutes[7:4];
			5'b0_0100: rdata_o = tm.hours[3:0];
			5'b0_0101: rdata_o = tm.hours[7:4];
			5'b0_0110: rdata_o = tm.dow;              // day of week before the date
			5'b0_0111: rdata_o = tm.day[3:0];
			5'b0_1000: rdata_o = tm.day[7:4];
			5'b0_1001: rdata_o = tm.month[3:0];
			5'b0_1010: rdata_o = tm.month[7:4];
			5'b0_1011: rdata_o = tm.year[3:0];
			5'b0_1100: rdata_o = tm.year[7:4] + `ST_RTC_YEAR_OFS;  // tens digit
			5'b?_1101: rdata_o = {1'b1, 2'b00, bank};  // mode with the timer enabled
			5'b?_1110: rdata_o = 4'h0;                 // test register
			5'b?_1111: rdata_o = 4'hc;                 // reset register
			default:   rdata_o = bank1[addr_i];        // bank 1 regs 0..12
		endcase
		// hide the chip until the io controller has sent a time
		if (tm == '0)
			rdata_o = 4'hf;
	end

endmodule

// ==== st_audio_mix.sv ====
`timescale 1ns/1ns

module st_audio_mix (
	input  logic                clk_32,
	input  logic                xsint,
	input  st_pkg::ym_sample_t  ym_l_i,
	input  st_pkg::ym_sample_t  ym_r_i,
	input  st_pkg::dma_sample_t dma_l_i,
	input  st_pkg::dma_sample_t dma_r_i,
	output st_pkg::mix_sample_t mix_l_o,
	output st_pkg::mix_sample_t mix_r_o
);

	import st_pkg::*;

	ym_sample_t  ym_l_s;  // offset removed, two's complement
	ym_sample_t  ym_r_s;
	dma_sample_t dma_l_s;
	dma_sample_t dma_r_s;

	// sign, value, then the msbs again to fill the low end
	function automatic mix_sample_t ym_expand(input ym_sample_t s);
		return {s[9], s, s[9:6]};
	endfunction

	function automatic mix_sample_t dma_expand(input dma_sample_t s);
		return {s[7], s, s[7:2]};
	endfunction

	assign ym_l_s  = ym_l_i - 10'h200;  // midpoint to zero
	assign ym_r_s  = ym_r_i - 10'h200;
	assign dma_l_s = dma_l_i - 8'h80;
	assign dma_r_s = dma_r_i - 8'h80;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= ym_expand(ym_l_s) + dma_expand(dma_l_s);  // wraps at 15 bits
			mix_r_o <= ym_expand(ym_r_s) + dma_expand(dma_r_s);
		end
	end

endmodule

// ==== st_axil_regs.sv ====
`timescale 1ns/1ns
`include "st_settings.svh"

module st_axil_regs (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic [`ST_AXI_AW-1:0] s_awaddr_i,
	input  logic                  s_awvalid_i,
	output logic                  s_awready_o,
	input  st_pkg::axi_data_t     s_wdata_i,
	input  logic                  s_wvalid_i,
	output logic                  s_wready_o,
	output st_pkg::axi_resp_t     s_bresp_o,
	output logic                  s_bvalid_o,
	input  logic                  s_bready_i,
	input  logic [`ST_AXI_AW-1:0] s_araddr_i,
	input  logic                  s_arvalid_i,
	output logic                  s_arready_o,
	output st_pkg::axi_data_t     s_rdata_o,
	output st_pkg::axi_resp_t     s_rresp_o,
	output logic                  s_rvalid_o,
	input  logic                  s_rready_i,
	output logic                  rtc_we_o,
	output st_pkg::rtc_addr_t     rtc_addr_o,
	output st_pkg::rtc_nib_t      rtc_wdata_o,
	output logic                  load_lo_o,
	output logic                  load_hi_o,
	output st_pkg::axi_data_t     load_data_o,
	input  st_pkg::rtc_nib_t      rtc_rdata_i
);

	import st_pkg::*;

	logic wr_acc;   // write accepted this cycle
	logic rd_acc;   // read accepted this cycle
	logic wr_rtc;   // 0x00..0x3c
	logic wr_lo;
	logic wr_hi;
	logic rd_rtc;
	logic rd_time;  // time regs read back as zero

	// aw and w must come together, one outstanding response each
	assign wr_acc = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
	// single rtc address port so a write takes the slot first
	assign rd_acc = s_arvalid_i && !s_rvalid_o && !wr_acc;

	assign s_awready_o = wr_acc;
	assign s_wready_o  = wr_acc;
	assign s_arready_o = rd_acc;

	// address decode
	assign wr_rtc  = s_awaddr_i < `ST_REG_TIME_LO;
	assign wr_lo   = s_awaddr_i == `ST_REG_TIME_LO;
	assign wr_hi   = s_awaddr_i == `ST_REG_TIME_HI;
	assign rd_rtc  = s_araddr_i < `ST_REG_TIME_LO;
	assign rd_time = (s_araddr_i == `ST_REG_TIME_LO) || (s_araddr_i == `ST_REG_TIME_HI);

	// strobes to the rtc, all in the accept cycle
	assign rtc_we_o    = wr_acc && wr_rtc;
	assign rtc_addr_o  = wr_acc ? s_awaddr_i[5:2] : s_araddr_i[5:2];  // word index
	assign rtc_wdata_o = s_wdata_i[3:0];
	assign load_lo_o   = wr_acc && wr_lo;
	assign load_hi_o   = wr_acc && wr_hi;
	assign load_data_o = s_wdata_i;

	// write response channel
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			s_bvalid_o <= 1'b0;
		else if (wr_acc)
			s_bvalid_o <= 1'b1;
		else if (s_bready_i)
			s_bvalid_o <= 1'b0;  // holds while bready is low
	end

	always_ff @(posedge clk_32) begin
		if (wr_acc)
			s_bresp_o <= (wr_rtc || wr_lo || wr_hi) ? resp_okay : resp_slverr;
	end

	// read data channel
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			s_rvalid_o <= 1'b0;
		else if (rd_acc)
			s_rvalid_o <= 1'b1;
		else if (s_rready_i)
			s_rvalid_o <= 1'b0;
	end

	// rtc nibble is sampled in the accept cycle
	always_ff @(posedge clk_32) begin
		if (rd_acc) begin
			if (rd_rtc) begin
				s_rdata_o <= {28'd0, rtc_rdata_i};
				s_rresp_o <= resp_okay;
			end else if (rd_time) begin
				s_rdata_o <= '0;  // load regs are write only
				s_rresp_o <= resp_okay;
			end else begin
				s_rdata_o <= '0;
				s_rresp_o <= resp_slverr;
			end
		end
	end

endmodule

// ==== st_glue_top.sv ====
`timescale 1ns/1ns
`include "st_settings.svh"

module st_glue_top (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  resb_i,
	input  logic [`ST_AXI_AW-1:0] s_awaddr_i,
	input  logic                  s_awvalid_i,
	output logic                  s_awready_o,
	input  st_pkg::axi_data_t     s_wdata_i,
	input  logic                  s_wvalid_i,
	output logic                  s_wready_o,
	output st_pkg::axi_resp_t     s_bresp_o,
	output logic                  s_bvalid_o,
	input  logic                  s_bready_i,
	input  logic [`ST_AXI_AW-1:0] s_araddr_i,
	input  logic                  s_arvalid_i,
	output logic                  s_arready_o,
	output st_pkg::axi_data_t     s_rdata_o,
	output st_pkg::axi_resp_t     s_rresp_o,
	output logic                  s_rvalid_o,
	input  logic                  s_rready_i,
	input  st_pkg::ym_sample_t    ym_l_i,
	input  st_pkg::ym_sample_t    ym_r_i,
	input  st_pkg::dma_sample_t   dma_l_i,
	input  st_pkg::dma_sample_t   dma_r_i,
	output st_pkg::mix_sample_t   mix_l_o,
	output st_pkg::mix_sample_t   mix_r_o,
	output logic                  clk_mfp_en_o,
	output logic                  clk_2_en_o,
	output logic                  reset_o,
	output logic                  mcu_reset_n_o
);

	import st_pkg::*;

	logic      periph_reset;  // clears the rtc bank bit
	logic      rtc_we;
	rtc_addr_t rtc_addr;
	rtc_nib_t  rtc_wdata;
	rtc_nib_t  rtc_rdata;
	logic      load_lo;
	logic      load_hi;
	axi_data_t load_data;     // time word from the host

	st_reset_seq u_reset_seq (
		.clk_32, .xsint, .resb_i,
		.reset_o, .periph_reset_o(periph_reset), .mcu_reset_n_o
	);

	st_clk_en u_clk_en (
		.clk_32, .xsint, .clk_mfp_en_o, .clk_2_en_o
	);

	st_rtc u_rtc (
		.clk_32, .xsint,
		.periph_reset_i(periph_reset),
		.we_i(rtc_we), .addr_i(rtc_addr), .wdata_i(rtc_wdata),
		.load_lo_i(load_lo), .load_hi_i(load_hi), .load_data_i(load_data),
		.rdata_o(rtc_rdata)
	);

	st_audio_mix u_audio_mix (
		.clk_32, .xsint,
		.ym_l_i, .ym_r_i, .dma_l_i, .dma_r_i,
		.mix_l_o, .mix_r_o
	);

	// host port, same names as the top so the bus connects by name
	st_axil_regs u_axil_regs (
		.clk_32, .xsint,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o,
		.s_wdata_i, .s_wvalid_i, .s_wready_o,
		.s_bresp_o, .s_bvalid_o, .s_bready_i,
		.s_araddr_i, .s_arvalid_i, .s_arready_o,
		.s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.rtc_we_o(rtc_we), .rtc_addr_o(rtc_addr), .rtc_wdata_o(rtc_wdata),
		.load_lo_o(load_lo), .load_hi_o(load_hi), .load_data_o(load_data),
		.rtc_rdata_i(rtc_rdata)
	);

endmodule

// ==== tb_st_glue.sv ====
`timescale 1ns/1ns
`include "st_settings.svh"

module tb_st_glue;

	logic                  clk_32;
	logic                  xsint;
	logic                  resb_i;
	logic [`ST_AXI_AW-1:0] s_awaddr_i;
	logic                  s_awvalid_i;
	logic                  s_awready_o;
	logic [31:0]           s_wdata_i;
	logic                  s_wvalid_i;
	logic                  s_wready_o;
	logic [1:0]            s_bresp_o;
	logic                  s_bvalid_o;
	logic                  s_bready_i;
	logic [`ST_AXI_AW-1:0] s_araddr_i;
	logic                  s_arvalid_i;
	logic                  s_arready_o;
	logic [31:0]           s_rdata_o;
	logic [1:0]            s_rresp_o;
	logic                  s_rvalid_o;
	logic                  s_rready_i;
	logic [9:0]            ym_l_i, ym_r_i;
	logic [7:0]            dma_l_i, dma_r_i;
	logic [14:0]           mix_l_o, mix_r_o;
	logic                  clk_mfp_en_o, clk_2_en_o, reset_o, mcu_reset_n_o;

	int          errors = 0;    // wrong values
	int          timeouts = 0;  // waits that ran out
	logic [31:0] seed = 32'h68e7_eb8f;
	logic        mfp_done = 1'b0;

	st_glue_top u_dut (.*);

	always #4 clk_32 = ~clk_32;  // 8 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t ns: %s", $time, msg);
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		assert (got === exp)
			else report_mismatch($sformatf("%s got %0h expected %0h", what, got, exp));
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout while waiting for %s", what);
	endtask

	// response channels hold under back-pressure and block new requests
	assert property (@(posedge clk_32) disable iff (!xsint)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o)
		else report_mismatch("bvalid dropped while bready low");
	assert property (@(posedge clk_32) disable iff (!xsint)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o)
		else report_mismatch("rvalid dropped while rready low");
	assert property (@(posedge clk_32) disable iff (!xsint)
		s_bvalid_o |-> !s_awready_o && !s_wready_o)
		else report_mismatch("write accepted with a response pending");
	assert property (@(posedge clk_32) disable iff (!xsint)
		s_rvalid_o |-> !s_arready_o)
		else report_mismatch("read accepted with a response pending");

	// expected 15-bit mix built from the signed value of each input
	function automatic logic [14:0] expected_mix(input logic [9:0] ym,
		input logic [7:0] dma);
		int yv;
		int dv;
		int sum;
		yv = int'(ym) - 512;   // -512..511
		dv = int'(dma) - 128;  // -128..127
		sum = yv * 16 + ((yv & 1023) >> 6) + dv * 64 + ((dv & 255) >> 2);
		return sum[14:0];
	endfunction

	// output at this negedge belongs to inputs seen one negedge ago
	logic [14:0] exp_l, exp_r;
	logic        exp_ok = 1'b0;
	always @(negedge clk_32) begin
		if (!xsint) begin
			exp_ok <= 1'b0;
		end else begin
			if (exp_ok) begin
				assert (mix_l_o == exp_l)
					else report_mismatch($sformatf("mix_l %0h vs %0h", mix_l_o, exp_l));
				assert (mix_r_o == exp_r)
					else report_mismatch($sformatf("mix_r %0h vs %0h", mix_r_o, exp_r));
			end
			exp_l  <= expected_mix(ym_l_i, dma_l_i);
			exp_r  <= expected_mix(ym_r_i, dma_r_i);
			exp_ok <= 1'b1;
		end
	end

	// clock enables counted in rising edges since the power-on release
	int cyc = 0, mfp_cnt = 0, mfp_last = -100, div_last = 0;
	always @(negedge clk_32) begin
		if (!xsint) begin
			cyc = 0;
		end else begin
			if (clk_2_en_o) begin
				assert (cyc - div_last == 16)
					else report_mismatch($sformatf("clk_2_en gap %0d", cyc - div_last));
				div_last = cyc;
			end
			if (clk_mfp_en_o && cyc <= 10000) begin
				assert (cyc - mfp_last > 12)
					else report_mismatch($sformatf("mfp gap %0d", cyc - mfp_last));
				mfp_last = cyc;
				mfp_cnt++;
			end
			if (cyc == 10000) begin
				assert (mfp_cnt >= 765 && mfp_cnt <= 767)
					else report_mismatch($sformatf("mfp count %0d", mfp_cnt));
				mfp_done = 1'b1;
			end
			cyc++;
		end
	end

	// call right after the edge that releases the reload
	task automatic check_reset_sequence();
		int   fall_at;
		int   mcu_first;
		int   mcu_low;
		logic was_high;
		fall_at = -1;
		mcu_first = -1;
		mcu_low = 0;
		was_high = 1'b0;
		for (int k = 0; k < 140; k++) begin
			@(negedge clk_32);  // k edges after the reload
			if (reset_o)
				was_high = 1'b1;
			else if (was_high && fall_at < 0)
				fall_at = k;
			if (!mcu_reset_n_o) begin
				mcu_low++;
				if (mcu_first < 0)
					mcu_first = k;
			end
		end
		check_value(fall_at, 128, "reset_o fall cycle");
		check_value(mcu_first, 118, "mcu reset start");  // cycle after the count of 10
		check_value(mcu_low, 3, "mcu reset length");    // counts 10, 9, 8
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int t;
		@(posedge clk_32);
		s_awaddr_i  <= addr;
		s_awvalid_i <= 1'b1;
		s_wdata_i   <= data;
		s_wvalid_i  <= 1'b1;
		for (t = 0; t < 50; t++) begin
			@(negedge clk_32);
			if (s_awready_o && s_wready_o)
				break;
		end
		if (t == 50)
			report_timeout("awready");
		@(posedge clk_32);
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		for (t = 0; t < 50; t++) begin
			@(negedge clk_32);
			if (s_bvalid_o)
				break;
		end
		if (t == 50)
			report_timeout("bvalid");
		resp = s_bresp_o;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int t;
		@(posedge clk_32);
		s_araddr_i  <= addr;
		s_arvalid_i <= 1'b1;
		for (t = 0; t < 50; t++) begin
			@(negedge clk_32);
			if (s_arready_o)
				break;
		end
		if (t == 50)
			report_timeout("arready");
		@(posedge clk_32);
		s_arvalid_i <= 1'b0;
		for (t = 0; t < 50; t++) begin
			@(negedge clk_32);
			if (s_rvalid_o)
				break;
		end
		if (t == 50)
			report_timeout("rvalid");
		data = s_rdata_o;
		resp = s_rresp_o;
	endtask

	initial begin
		logic [31:0] rd;
		logic [1:0]  rsp;
		logic [3:0]  exp_b0 [16];
		logic [3:0]  b1 [13];
		int          t;
		clk_32 = 1'b0;
		xsint = 1'b0;
		resb_i = 1'b1;
		s_awaddr_i = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b1;
		s_araddr_i = '0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b1;
		ym_l_i = 10'h200;
		ym_r_i = 10'h200;
		dma_l_i = 8'h80;
		dma_r_i = 8'h80;
		// time 19:37:45, day 28, month 11, year 26, dow 3
		exp_b0 = '{4'h5, 4'h4, 4'h7, 4'h3, 4'h9, 4'h1, 4'h3, 4'h8,
			4'h2, 4'h1, 4'h1, 4'h6, 4'h4, 4'h8, 4'h0, 4'hc};  // year tens 2+2

		repeat (2) @(posedge clk_32);
		xsint <= 1'b1;
		check_reset_sequence();
		@(posedge clk_32);
		resb_i <= 1'b0;  // button pulse
		@(posedge clk_32);
		resb_i <= 1'b1;
		check_reset_sequence();

		repeat (300) begin
			@(posedge clk_32);
			seed = xorshift(seed);
			ym_l_i  <= seed[9:0];
			ym_r_i  <= seed[19:10];
			dma_l_i <= seed[27:20];
			seed = xorshift(seed);
			dma_r_i <= seed[7:0];
		end

		// chip hidden while the time is zero
		for (int i = 0; i < 16; i++) begin
			axi_read(8'(i * 4), rd, rsp);
			check_value(rd, 32'hf, $sformatf("hidden reg %0d", i));
		end
		axi_write(`ST_REG_TIME_LO, 32'h2819_3745, rsp);
		check_value(32'(rsp), 32'h0, "time lo resp");
		axi_write(`ST_REG_TIME_HI, 32'h0003_2611, rsp);
		check_value(32'(rsp), 32'h0, "time hi resp");
		for (int i = 0; i < 16; i++) begin
			axi_read(8'(i * 4), rd, rsp);
			check_value(rd, 32'(exp_b0[i]), $sformatf("bank0 reg %0d", i));
			check_value(32'(rsp), 32'h0, "rtc read resp");
		end

		axi_write(8'h34, 32'h1, rsp);  // bank 1
		axi_read(8'h34, rd, rsp);
		check_value(rd, 32'h9, "mode in bank 1");
		for (int i = 0; i < 13; i++) begin
			seed = xorshift(seed);
			b1[i] = seed[3:0];
			axi_write(8'(i * 4), {28'h0, b1[i]}, rsp);
		end
		for (int i = 0; i < 13; i++) begin
			axi_read(8'(i * 4), rd, rsp);
			check_value(rd, 32'(b1[i]), $sformatf("bank1 reg %0d", i));
		end
		axi_write(8'h34, 32'h0, rsp);
		for (int i = 0; i < 16; i++) begin
			axi_read(8'(i * 4), rd, rsp);
			check_value(rd, 32'(exp_b0[i]), $sformatf("bank0 again reg %0d", i));
		end

		axi_write(8'h84, 32'h5, rsp);
		check_value(32'(rsp), 32'h2, "unmapped write resp");
		axi_read(8'hc0, rd, rsp);
		check_value(32'(rsp), 32'h2, "unmapped read resp");
		check_value(rd, 32'h0, "unmapped read data");

		// second request waits behind the held response
		@(posedge clk_32);
		s_bready_i <= 1'b0;
		s_rready_i <= 1'b0;
		axi_write(8'h00, 32'h3, rsp);
		@(posedge clk_32);
		s_awvalid_i <= 1'b1;
		s_wvalid_i  <= 1'b1;
		repeat (5) begin
			@(negedge clk_32);
			assert (s_bvalid_o && !s_awready_o)
				else report_mismatch("write accepted under bready low");
		end
		@(posedge clk_32);
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		s_bready_i  <= 1'b1;
		axi_read(8'h00, rd, rsp);
		@(posedge clk_32);
		s_arvalid_i <= 1'b1;
		repeat (5) begin
			@(negedge clk_32);
			assert (s_rvalid_o && !s_arready_o)
				else report_mismatch("read accepted under rready low");
		end
		@(posedge clk_32);
		s_arvalid_i <= 1'b0;
		s_rready_i  <= 1'b1;

		for (t = 0; t < 20000 && !mfp_done; t++)
			@(posedge clk_32);
		if (!mfp_done)
			report_timeout("mfp count window");
		repeat (2) @(posedge clk_32);

		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
st_pkg.sv
st_reset_seq.sv
st_clk_en.sv
st_rtc.sv
st_audio_mix.sv
st_axil_regs.sv
st_glue_top.sv
tb_st_glue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_st_glue -Mdir obj_dir
./obj_dir/Vtb_st_glue 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
